// File: common/pulp_cfg_pkg.sv
// bus widths, memory geometry constants and host-side vector types
`default_nettype none

package pulp_cfg_pkg;

  // addressing
  localparam int unsigned AXI_AW = 32;

  // data path, one strobe bit per byte
  localparam int unsigned AXI_DW = 64;
  localparam int unsigned AXI_SW = AXI_DW / 8;

  // wide transaction id seen by the host
  localparam int unsigned AXI_IW_SLV = 8;

  // byte offset inside one data word
  localparam int unsigned WORD_OFFSET_W = $clog2(AXI_SW);

  typedef logic [AXI_AW-1:0]     addr_t;
  typedef logic [AXI_DW-1:0]     data_t;
  typedef logic [AXI_SW-1:0]     strb_t;
  typedef logic [AXI_IW_SLV-1:0] ext_id_t;

endpackage

`default_nettype wire

// File: common/pulp_txn_pkg.sv
// transaction opcode and l2 sequencer state enums
`default_nettype none

package pulp_txn_pkg;

  // request kind carried through the queue
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } txn_op_e;

  // l2 memory sequencer, one access per three cycles
  typedef enum logic [1:0] {
    L2_IDLE   = 2'd0,
    L2_ACCESS = 2'd1,
    L2_RESP   = 2'd2
  } l2_state_e;

endpackage

`default_nettype wire

// File: rtl/id_remap/id_remap.sv
// id_remap: slot allocation, external id table, response id restore and busy
`timescale 1ns/1ps
`default_nettype none

module id_remap
  import pulp_cfg_pkg::*;
  import pulp_txn_pkg::*;
#(
  parameter int unsigned TABLE_SIZE = 4,
  localparam int unsigned SLOT_W = (TABLE_SIZE > 1) ? $clog2(TABLE_SIZE) : 1
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // host side
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  ext_id_t           req_id_i,
  input  addr_t             req_addr_i,
  input  data_t             req_wdata_i,
  input  strb_t             req_strb_i,
  output logic              req_err_o,
  output logic              busy_o,
  output logic              rsp_valid_o,
  output ext_id_t           rsp_id_o,
  output logic              rsp_write_o,
  output data_t             rsp_rdata_o,
  // queue side
  output logic              push_o,
  output txn_op_e           push_op_o,
  output addr_t             push_addr_o,
  output data_t             push_wdata_o,
  output strb_t             push_strb_o,
  output logic [SLOT_W-1:0] push_slot_o,
  // memory side
  input  logic              mem_rsp_valid_i,
  input  logic [SLOT_W-1:0] mem_rsp_slot_i,
  input  txn_op_e           mem_rsp_op_i,
  input  data_t             mem_rsp_rdata_i
);

  // per-slot state
  logic [TABLE_SIZE-1:0] slot_valid_q;
  ext_id_t               slot_id_q [TABLE_SIZE];

  logic [TABLE_SIZE-1:0] slot_free;
  logic                  any_free;
  logic [SLOT_W-1:0]     free_slot;

  // a slot released by this cycle's response is reusable right away
  always_comb begin
    for (int i = 0; i < TABLE_SIZE; i++) begin
      slot_free[i] = !slot_valid_q[i] ||
                     (mem_rsp_valid_i && (mem_rsp_slot_i == SLOT_W'(i)));
    end
  end

  // lowest free slot wins, so scan from the top down
  always_comb begin
    any_free  = 1'b0;
    free_slot = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (slot_free[i]) begin
        any_free  = 1'b1;
        free_slot = SLOT_W'(i);
      end
    end
  end

  // accept or refuse in the request cycle
  assign push_o    = req_valid_i && any_free;
  assign req_err_o = req_valid_i && !any_free;

  assign push_op_o    = req_write_i ? OP_WRITE : OP_READ;
  assign push_addr_o  = req_addr_i;
  assign push_wdata_o = req_wdata_i;
  assign push_strb_o  = req_strb_i;
  assign push_slot_o  = free_slot;

  // release first, then claim, so a freed slot can be taken in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_valid_q <= '0;
    end else begin
      if (mem_rsp_valid_i) begin
        slot_valid_q[mem_rsp_slot_i] <= 1'b0;
      end
      if (push_o) begin
        slot_valid_q[free_slot] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_o) begin
      slot_id_q[free_slot] <= req_id_i;
    end
  end

  // response goes straight back with the original host id
  assign rsp_valid_o = mem_rsp_valid_i;
  assign rsp_id_o    = slot_id_q[mem_rsp_slot_i];
  assign rsp_write_o = (mem_rsp_op_i == OP_WRITE);
  assign rsp_rdata_o = mem_rsp_rdata_i;

  // any slot in flight
  assign busy_o = |slot_valid_q;

endmodule

`default_nettype wire

// File: rtl/req_queue.sv
// req_queue: circular FIFO of remapped requests with occupancy count
`timescale 1ns/1ps
`default_nettype none

module req_queue
  import pulp_cfg_pkg::*;
  import pulp_txn_pkg::*;
#(
  parameter int unsigned DEPTH = 4,
  localparam int unsigned SLOT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CNT_W  = $clog2(DEPTH + 1)
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              push_i,
  input  logic              pop_i,
  input  txn_op_e           push_op_i,
  input  addr_t             push_addr_i,
  input  data_t             push_wdata_i,
  input  strb_t             push_strb_i,
  input  logic [SLOT_W-1:0] push_slot_i,
  output logic              not_empty_o,
  output txn_op_e           head_op_o,
  output addr_t             head_addr_o,
  output data_t             head_wdata_o,
  output strb_t             head_strb_o,
  output logic [SLOT_W-1:0] head_slot_o
);

  // storage
  txn_op_e           op_q    [DEPTH];
  addr_t             addr_q  [DEPTH];
  data_t             wdata_q [DEPTH];
  strb_t             strb_q  [DEPTH];
  logic [SLOT_W-1:0] slot_q  [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // explicit wrap keeps non power-of-two depths working
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      op_q[wr_ptr_q]    <= push_op_i;
      addr_q[wr_ptr_q]  <= push_addr_i;
      wdata_q[wr_ptr_q] <= push_wdata_i;
      strb_q[wr_ptr_q]  <= push_strb_i;
      slot_q[wr_ptr_q]  <= push_slot_i;
    end
  end

  // oldest entry at the head
  assign not_empty_o  = (count_q != '0);
  assign head_op_o    = op_q[rd_ptr_q];
  assign head_addr_o  = addr_q[rd_ptr_q];
  assign head_wdata_o = wdata_q[rd_ptr_q];
  assign head_strb_o  = strb_q[rd_ptr_q];
  assign head_slot_o  = slot_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: rtl/l2_mem/l2_mem.sv
// l2_mem: scratchpad array with byte-strobed writes and access sequencer FSM
`timescale 1ns/1ps
`default_nettype none

module l2_mem
  import pulp_cfg_pkg::*;
  import pulp_txn_pkg::*;
#(
  // must be a power of two
  parameter int unsigned L2_N_WORDS = 64,
  parameter int unsigned TABLE_SIZE = 4,
  localparam int unsigned SLOT_W = (TABLE_SIZE > 1) ? $clog2(TABLE_SIZE) : 1,
  localparam int unsigned IDX_W  = (L2_N_WORDS > 1) ? $clog2(L2_N_WORDS) : 1
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // queue head
  input  logic              not_empty_i,
  input  txn_op_e           head_op_i,
  input  addr_t             head_addr_i,
  input  data_t             head_wdata_i,
  input  strb_t             head_strb_i,
  input  logic [SLOT_W-1:0] head_slot_i,
  output logic              pop_o,
  // response
  output logic              rsp_valid_o,
  output logic [SLOT_W-1:0] rsp_slot_o,
  output txn_op_e           rsp_op_o,
  output data_t             rsp_rdata_o
);

  l2_state_e state_q;
  l2_state_e state_d;

  // request latched at pop
  txn_op_e           op_q;
  logic [IDX_W-1:0]  idx_q;
  data_t             wdata_q;
  strb_t             strb_q;
  logic [SLOT_W-1:0] slot_q;
  data_t             rdata_q;

  data_t mem_q [L2_N_WORDS];

  // scratchpad powers up cleared
  initial begin
    for (int w = 0; w < L2_N_WORDS; w++) begin
      mem_q[w] = '0;
    end
  end

  // take the head only when idle
  assign pop_o = (state_q == L2_IDLE) && not_empty_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      L2_IDLE: begin
        if (not_empty_i) begin
          state_d = L2_ACCESS;
        end
      end
      L2_ACCESS: state_d = L2_RESP;
      L2_RESP:   state_d = L2_IDLE;
      default:   state_d = L2_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= L2_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // word index sits just above the byte offset, upper bits alias
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      op_q    <= head_op_i;
      idx_q   <= head_addr_i[WORD_OFFSET_W +: IDX_W];
      wdata_q <= head_wdata_i;
      strb_q  <= head_strb_i;
      slot_q  <= head_slot_i;
    end
  end

  // only strobed bytes change
  always @(posedge clk_i) begin
    if ((state_q == L2_ACCESS) && (op_q == OP_WRITE)) begin
      for (int b = 0; b < AXI_SW; b++) begin
        if (strb_q[b]) begin
          mem_q[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (state_q == L2_ACCESS) begin
      rdata_q <= (op_q == OP_READ) ? mem_q[idx_q] : '0;
    end
  end

  assign rsp_valid_o = (state_q == L2_RESP);
  assign rsp_slot_o  = slot_q;
  assign rsp_op_o    = op_q;
  assign rsp_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rtl/pulp_lite.sv
// pulp_lite top level: id remapper, request queue and l2 scratchpad
`timescale 1ns/1ps
`default_nettype none

module pulp_lite
  import pulp_cfg_pkg::*;
  import pulp_txn_pkg::*;
#(
  parameter int unsigned TABLE_SIZE = 4,
  // must be a power of two
  parameter int unsigned L2_N_WORDS = 64
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // host request
  input  logic    req_valid_i,
  input  logic    req_write_i,
  input  ext_id_t req_id_i,
  input  addr_t   req_addr_i,
  input  data_t   req_wdata_i,
  input  strb_t   req_strb_i,
  output logic    req_err_o,
  // host response
  output logic    rsp_valid_o,
  output logic    rsp_write_o,
  output ext_id_t rsp_id_o,
  output data_t   rsp_rdata_o,
  output logic    busy_o
);

  localparam int unsigned SLOT_W = (TABLE_SIZE > 1) ? $clog2(TABLE_SIZE) : 1;

  // remapper to queue
  logic              push;
  txn_op_e           push_op;
  addr_t             push_addr;
  data_t             push_wdata;
  strb_t             push_strb;
  logic [SLOT_W-1:0] push_slot;

  // queue head to memory
  logic              not_empty;
  logic              pop;
  txn_op_e           head_op;
  addr_t             head_addr;
  data_t             head_wdata;
  strb_t             head_strb;
  logic [SLOT_W-1:0] head_slot;

  // memory response back to remapper
  logic              mem_rsp_valid;
  logic [SLOT_W-1:0] mem_rsp_slot;
  txn_op_e           mem_rsp_op;
  data_t             mem_rsp_rdata;

  id_remap #(
    .TABLE_SIZE (TABLE_SIZE)
  ) i_id_remap (
    .clk_i,
    .arst_n_i,
    .req_valid_i,
    .req_write_i,
    .req_id_i,
    .req_addr_i,
    .req_wdata_i,
    .req_strb_i,
    .req_err_o,
    .busy_o,
    .rsp_valid_o,
    .rsp_id_o,
    .rsp_write_o,
    .rsp_rdata_o,
    .push_o          (push),
    .push_op_o       (push_op),
    .push_addr_o     (push_addr),
    .push_wdata_o    (push_wdata),
    .push_strb_o     (push_strb),
    .push_slot_o     (push_slot),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_slot_i  (mem_rsp_slot),
    .mem_rsp_op_i    (mem_rsp_op),
    .mem_rsp_rdata_i (mem_rsp_rdata)
  );

  // queue depth equals the slot count, so it cannot overflow
  req_queue #(
    .DEPTH (TABLE_SIZE)
  ) i_req_queue (
    .clk_i,
    .arst_n_i,
    .push_i       (push),
    .pop_i        (pop),
    .push_op_i    (push_op),
    .push_addr_i  (push_addr),
    .push_wdata_i (push_wdata),
    .push_strb_i  (push_strb),
    .push_slot_i  (push_slot),
    .not_empty_o  (not_empty),
    .head_op_o    (head_op),
    .head_addr_o  (head_addr),
    .head_wdata_o (head_wdata),
    .head_strb_o  (head_strb),
    .head_slot_o  (head_slot)
  );

  l2_mem #(
    .L2_N_WORDS (L2_N_WORDS),
    .TABLE_SIZE (TABLE_SIZE)
  ) i_l2_mem (
    .clk_i,
    .arst_n_i,
    .not_empty_i  (not_empty),
    .head_op_i    (head_op),
    .head_addr_i  (head_addr),
    .head_wdata_i (head_wdata),
    .head_strb_i  (head_strb),
    .head_slot_i  (head_slot),
    .pop_o        (pop),
    .rsp_valid_o  (mem_rsp_valid),
    .rsp_slot_o   (mem_rsp_slot),
    .rsp_op_o     (mem_rsp_op),
    .rsp_rdata_o  (mem_rsp_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_pulp_lite_model.svh
// reference model: outstanding count, expected response queue and memory image
`ifndef TB_PULP_LITE_MODEL_SVH
`define TB_PULP_LITE_MODEL_SVH

// transactions accepted and not yet answered
int unsigned outstanding;

// expected responses in acceptance order
ext_id_t exp_id_q    [$];
logic    exp_write_q [$];
data_t   exp_rdata_q [$];

data_t model_mem [L2_N_WORDS];

// word index sits above the byte offset, upper address bits wrap
function automatic int unsigned word_of(input addr_t addr);
  return (addr >> WORD_OFFSET_W) % L2_N_WORDS;
endfunction

task automatic model_reset();
  outstanding = 0;
  exp_id_q.delete();
  exp_write_q.delete();
  exp_rdata_q.delete();
  for (int w = 0; w < L2_N_WORDS; w++) begin
    model_mem[w] = '0;
  end
endtask

// the memory serves in acceptance order, so the access can be applied right away
task automatic model_accept(input logic write, input ext_id_t id, input addr_t addr,
                            input data_t wdata, input strb_t strb);
  int unsigned w;
  data_t       merged;
  w = word_of(addr);
  if (write) begin
    merged = model_mem[w];
    for (int b = 0; b < AXI_SW; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    model_mem[w] = merged;
    exp_rdata_q.push_back('0);
  end else begin
    exp_rdata_q.push_back(model_mem[w]);
  end
  exp_id_q.push_back(id);
  exp_write_q.push_back(write);
  outstanding++;
endtask

// refused only when all slots are taken and none is released this cycle
function automatic logic model_refuses(input logic valid, input logic freeing);
  return valid && (outstanding == TABLE_SIZE) && !freeing;
endfunction

`endif

// File: dv/tb_pulp_lite.sv
// testbench for pulp_lite: clock, reset, LFSR stimulus, checks and reporting
`timescale 1ns/1ps
`default_nettype none

module tb_pulp_lite
  import pulp_cfg_pkg::*;
  import pulp_txn_pkg::*;
;

  localparam int unsigned TABLE_SIZE = 4;
  localparam int unsigned L2_N_WORDS = 64;

  localparam int unsigned N_WR    = 12;
  localparam int unsigned N_BURST = 24;
  localparam int unsigned N_ALIAS = 6;
  localparam int unsigned N_REQ   = 2 * N_WR + N_BURST + 2 * N_ALIAS;
  localparam int unsigned TIMEOUT_CYCLES = 16 * N_REQ + 100;

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic    clk_i;
  logic    arst_n_i;
  logic    req_valid_i;
  logic    req_write_i;
  ext_id_t req_id_i;
  addr_t   req_addr_i;
  data_t   req_wdata_i;
  strb_t   req_strb_i;
  logic    req_err_o;
  logic    rsp_valid_o;
  logic    rsp_write_o;
  ext_id_t rsp_id_o;
  data_t   rsp_rdata_o;
  logic    busy_o;

  logic [31:0] lfsr_q = 32'd41;
  int unsigned errors;
  int unsigned errors_base;
  int unsigned checks;
  int unsigned tests_run;
  int unsigned refused;
  int unsigned cycle_cnt;
  addr_t       wr_addr [N_WR];

  `include "tb_pulp_lite_model.svh"

  pulp_lite #(
    .TABLE_SIZE (TABLE_SIZE),
    .L2_N_WORDS (L2_N_WORDS)
  ) dut_i (
    .clk_i, .arst_n_i, .req_valid_i, .req_write_i, .req_id_i, .req_addr_i,
    .req_wdata_i, .req_strb_i, .req_err_o, .rsp_valid_o, .rsp_write_o,
    .rsp_id_o, .rsp_rdata_o, .busy_o
  );

  always #20 clk_i = ~clk_i;

  // run limit scales with the number of requests
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d responses never arrived", cycle_cnt, outstanding);
      $display("Finished with errors");
      $finish;
    end
  end

  // galois shift register stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic flag_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  // outputs are read at the rising edge, before the flops move
  task automatic sample_and_check();
    logic exp_err;
    logic exp_busy;
    exp_err  = model_refuses(req_valid_i, rsp_valid_o);
    exp_busy = (outstanding != 0);
    checks += 2;
    if (req_err_o !== exp_err) flag_mismatch("req_err_o", req_err_o, exp_err);
    if (busy_o !== exp_busy) flag_mismatch("busy_o", busy_o, exp_busy);
    if (rsp_valid_o === 1'b1) begin
      checks++;
      if (exp_id_q.size() == 0) begin
        flag_error("response arrived while no request was outstanding");
      end else begin
        if (rsp_id_o !== exp_id_q[0]) flag_mismatch("rsp_id_o", rsp_id_o, exp_id_q[0]);
        if (rsp_write_o !== exp_write_q[0]) begin
          flag_mismatch("rsp_write_o", rsp_write_o, exp_write_q[0]);
        end
        if (rsp_rdata_o !== exp_rdata_q[0]) begin
          flag_mismatch("rsp_rdata_o", rsp_rdata_o, exp_rdata_q[0]);
        end
        void'(exp_id_q.pop_front());
        void'(exp_write_q.pop_front());
        void'(exp_rdata_q.pop_front());
        outstanding--;
      end
    end
    if (req_valid_i && exp_err) refused++;
    if (req_valid_i && !exp_err) begin
      model_accept(req_write_i, req_id_i, req_addr_i, req_wdata_i, req_strb_i);
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic write, input ext_id_t id,
                             input addr_t addr, input data_t wdata, input strb_t strb);
    @(negedge clk_i);
    req_valid_i = valid;
    req_write_i = write;
    req_id_i    = id;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    @(posedge clk_i);
    sample_and_check();
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, '0, '0, '0, '0);
  endtask

  // hold off until a slot is surely free
  task automatic wait_for_slot();
    while (outstanding >= TABLE_SIZE) idle_cycle();
  endtask

  // one extra idle cycle checks that busy_o has dropped
  task automatic drain();
    while (outstanding != 0) idle_cycle();
    idle_cycle();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %s done, %0d errors", name, errors - errors_base);
    errors_base = errors;
  endtask

  initial begin
    addr_t a;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_id_i = '0;
    req_addr_i = '0;
    req_wdata_i = '0;
    req_strb_i = '0;
    model_reset();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // quiet outputs out of reset
    checks += 3;
    if (req_err_o !== 1'b0) flag_mismatch("req_err_o", req_err_o, 0);
    if (rsp_valid_o !== 1'b0) flag_mismatch("rsp_valid_o", rsp_valid_o, 0);
    if (busy_o !== 1'b0) flag_mismatch("busy_o", busy_o, 0);
    finish_test("reset");

    for (int i = 0; i < N_WR; i++) begin
      wr_addr[i] = addr_t'(rand_bits(32));
      wait_for_slot();
      drive_cycle(1'b1, 1'b1, ext_id_t'(rand_bits(8)), wr_addr[i], rand_bits(64),
                  strb_t'(rand_bits(8)));
    end
    for (int i = 0; i < N_WR; i++) begin
      wait_for_slot();
      drive_cycle(1'b1, 1'b0, ext_id_t'(rand_bits(8)), wr_addr[i], '0, '0);
    end
    drain();
    finish_test("write_read");

    // back to back requests over a few words until slots run out
    for (int i = 0; i < N_BURST; i++) begin
      a = addr_t'((rand_bits(3) << WORD_OFFSET_W) | rand_bits(3));
      drive_cycle(1'b1, (rand_bits(1) != 0), ext_id_t'(rand_bits(8)), a, rand_bits(64),
                  strb_t'(rand_bits(8)));
    end
    drain();
    if (refused == 0) flag_error("burst never ran out of slots");
    finish_test("burst");

    for (int i = 0; i < N_ALIAS; i++) begin
      a = addr_t'(rand_bits(32));
      wait_for_slot();
      drive_cycle(1'b1, 1'b1, ext_id_t'(rand_bits(8)), a, rand_bits(64), '1);
      a = addr_t'(a + (L2_N_WORDS * AXI_SW) * (1 + rand_bits(4)));
      wait_for_slot();
      drive_cycle(1'b1, 1'b0, ext_id_t'(rand_bits(8)), a, '0, '0);
    end
    drain();
    finish_test("alias");

    $display("tests %0d, checks %0d, refused %0d, errors %0d",
             tests_run, checks, refused, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pulp_lite.f
+incdir+dv
common/pulp_cfg_pkg.sv
common/pulp_txn_pkg.sv
rtl/id_remap/id_remap.sv
rtl/req_queue.sv
rtl/l2_mem/l2_mem.sv
rtl/pulp_lite.sv
dv/tb_pulp_lite.sv

// File: Bender.yml
package:
  name: pulp_lite

sources:
  # shared packages
  - files:
      - common/pulp_cfg_pkg.sv
      - common/pulp_txn_pkg.sv
  # design
  - files:
      - rtl/id_remap/id_remap.sv
      - rtl/req_queue.sv
      - rtl/l2_mem/l2_mem.sv
      - rtl/pulp_lite.sv
  # testbench
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_pulp_lite.sv
